/* logic/qspi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, fixed commands, register map and state types
// for the quad-SPI memory controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package qspi_pkg;

	localparam int host_adr_w = 26;
	localparam int dev_adr_w = 24;
	localparam int data_w = 32;
	localparam int lat_w = 4;
	localparam int div_w = 10;

	// quad read and quad write opcodes
	localparam logic [7:0] read_cmd = 8'heb;
	localparam logic [7:0] write_cmd = 8'h38;

	// configuration bus word addresses
	localparam int cfg_adr_w = 4;
	localparam logic [cfg_adr_w-1:0] reg_latency0 = 4'd0;
	localparam logic [cfg_adr_w-1:0] reg_latency1 = 4'd1;
	localparam logic [cfg_adr_w-1:0] reg_latency2 = 4'd2;
	localparam logic [cfg_adr_w-1:0] reg_sckdiv = 4'd3;

	localparam logic [div_w-1:0] sckdiv_default = 10'd3;
	localparam logic [lat_w-1:0] latency_default = 4'd6;

	typedef enum logic [1:0] {
		size_byte,
		size_half,
		size_word
	} size_t;

	typedef enum logic [3:0] {
		st_idle,
		st_cs_setup,
		st_cmd,
		st_adr,
		st_wait,
		st_rdata,
		st_wdata,
		st_cs_release
	} qspi_state_t;

	// what the shifter puts on sio in the current period
	typedef enum logic [1:0] {
		ph_none,
		ph_cmd,
		ph_nibble,
		ph_read
	} phase_t;

endpackage

`default_nettype wire

/* logic/qspi_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free running SCK divider with fall and rise strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module qspi_clock_gen
	import qspi_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [div_w-1:0] sck_div,
	output logic             sck,
	output logic             fall_edge,
	output logic             rise_edge
);

	logic [div_w-1:0] cnt;
	logic             sck_int;
	logic [5:0]       sck_dly;
	logic             wrap;

	// >= so a smaller divider written mid count wraps at once
	assign wrap = (cnt >= sck_div);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			sck_int <= 1'b1;
		end else if (wrap) begin
			cnt <= '0;
			sck_int <= ~sck_int;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_dly <= '1;
		end else begin
			sck_dly <= {sck_dly[4:0], sck_int};
		end
	end

	// pin sck trails the fall strobe by two clocks, like the registered sio
	assign sck = sck_dly[1];
	assign fall_edge = sck_dly[0] & ~sck_int;
	// pin rise plus three synchronizer flops
	assign rise_edge = sck_dly[4] & ~sck_dly[5];

endmodule

`default_nettype wire

/* logic/qspi_config_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCK divider and per-device read latency registers,
// written on cfg_we and read back one cycle after cfg_re
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module qspi_config_regs
	import qspi_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      cfg_we,
	input  logic                      cfg_re,
	input  logic [cfg_adr_w-1:0]      cfg_adr,
	input  logic [data_w-1:0]         cfg_wdata,
	output logic [data_w-1:0]         cfg_rdata,
	output logic [div_w-1:0]          sck_div,
	output logic [2:0][lat_w-1:0]     read_latency
);

	logic                 rd_valid;
	logic [cfg_adr_w-1:0] rd_adr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_div <= sckdiv_default;
			read_latency <= {3{latency_default}};
		end else if (cfg_we) begin
			case (cfg_adr)
				reg_latency0: read_latency[0] <= cfg_wdata[lat_w-1:0];
				reg_latency1: read_latency[1] <= cfg_wdata[lat_w-1:0];
				reg_latency2: read_latency[2] <= cfg_wdata[lat_w-1:0];
				reg_sckdiv: sck_div <= cfg_wdata[div_w-1:0];
				default: ;
			endcase
		end
	end

	// read select held for one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			rd_adr <= '0;
		end else begin
			rd_valid <= cfg_re;
			if (cfg_re)
				rd_adr <= cfg_adr;
		end
	end

	always_comb begin
		cfg_rdata = '0;
		if (rd_valid) begin
			case (rd_adr)
				reg_latency0: cfg_rdata = data_w'(read_latency[0]);
				reg_latency1: cfg_rdata = data_w'(read_latency[1]);
				reg_latency2: cfg_rdata = data_w'(read_latency[2]);
				reg_sckdiv: cfg_rdata = data_w'(sck_div);
				default: cfg_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/qspi_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host request capture, req/ack handshake and the transfer FSM;
// every state lasts whole SCK periods, fall strobe to fall strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module qspi_sequencer
	import qspi_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  logic                  fall_edge,
	input  size_t                 size,
	input  logic [host_adr_w-1:0] adr,
	input  logic [data_w-1:0]     wdata,
	input  logic [2:0][lat_w-1:0] read_latency,
	output logic                  ack,
	output logic [2:0]            ce_n,
	output phase_t                phase,
	output logic [dev_adr_w-1:0]  dev_adr,
	output size_t                 cur_size,
	output logic [data_w-1:0]     cur_wdata,
	output logic                  cur_we,
	output logic                  phase_start,
	input  logic                  nibble_done
);

	qspi_state_t           state;
	qspi_state_t           state_nxt;
	logic [host_adr_w-1:0] adr_q;
	logic                  pending;
	logic                  take;
	logic                  start;
	logic                  selected;
	logic [lat_w-1:0]      cnt;
	logic [lat_w-1:0]      data_last;
	logic [lat_w-1:0]      sel_lat;
	logic [lat_w-1:0]      rd_left;

	function automatic phase_t phase_of(input qspi_state_t s);
		case (s)
			st_cmd: return ph_cmd;
			st_adr, st_wdata: return ph_nibble;
			st_rdata: return ph_read;
			default: return ph_none;
		endcase
	endfunction

	// no new request while ack is still high
	assign take = req & ~ack & ~pending & (state == st_idle);
	assign start = fall_edge & pending & (state == st_idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			cur_we <= 1'b0;
			cur_size <= size_byte;
		end else if (take) begin
			pending <= 1'b1;
			cur_we <= we;
			cur_size <= size;
		end else if (start) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			adr_q <= adr;
			cur_wdata <= wdata;
		end
	end

	assign dev_adr = adr_q[dev_adr_w-1:0];

	always_comb begin
		case (cur_size)
			size_byte: data_last = 4'd1;
			size_half: data_last = 4'd3;
			default: data_last = 4'd7;
		endcase
		case (adr_q[25:24])
			2'd1: sel_lat = read_latency[1];
			2'd2: sel_lat = read_latency[2];
			default: sel_lat = read_latency[0];
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (pending) state_nxt = st_cs_setup;
			st_cs_setup: state_nxt = st_cmd;
			st_cmd: if (cnt == 4'd7) state_nxt = st_adr;
			st_adr: begin
				if (cnt == 4'd5) begin
					if (cur_we)
						state_nxt = st_wdata;
					else if (sel_lat == '0)
						state_nxt = st_rdata;
					else
						state_nxt = st_wait;
				end
			end
			st_wait: if (cnt == sel_lat - 1'b1) state_nxt = st_rdata;
			st_rdata, st_wdata: if (cnt == data_last) state_nxt = st_cs_release;
			// hold until the last read nibble is through the synchronizer
			st_cs_release: if (rd_left == '0) state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cnt <= '0;
		end else if (fall_edge) begin
			state <= state_nxt;
			if (state_nxt != state)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	// read nibbles still to come back from the shifter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_left <= '0;
		else if (start)
			rd_left <= cur_we ? '0 : data_last + 1'b1;
		else if (nibble_done)
			rd_left <= rd_left - 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack <= 1'b0;
		else if (fall_edge && state == st_cs_release && state_nxt == st_idle)
			ack <= 1'b1;
		else if (!req)
			ack <= 1'b0;
	end

	// device 3 decodes to no select
	assign selected = state inside {st_cmd, st_adr, st_wait, st_rdata, st_wdata};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ce_n <= 3'b111;
		else
			ce_n <= selected ? ~(3'b001 << adr_q[25:24]) : 3'b111;
	end

	assign phase = phase_of(state);
	assign phase_start = fall_edge & (phase_of(state_nxt) != phase);

endmodule

`default_nettype wire

/* logic/qspi_shifter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sio driver and sampler: command, address and write nibbles out,
// read nibbles in through a 3-flop synchronizer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module qspi_shifter
	import qspi_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fall_edge,
	input  logic                 rise_edge,
	input  logic                 phase_start,
	input  logic                 cur_we,
	input  phase_t               phase,
	input  logic [dev_adr_w-1:0] dev_adr,
	input  size_t                cur_size,
	input  logic [data_w-1:0]    cur_wdata,
	inout  wire  [3:0]           sio,
	output logic                 nibble_done,
	output logic [data_w-1:0]    rdata
);

	logic [3:0]        idx;
	logic [7:0]        cmd_byte;
	logic [2:0]        adr_pos;
	logic [2:0]        wr_pos;
	logic [3:0]        adr_nib;
	logic [3:0]        wr_nib;
	logic [3:0]        out_pre;
	logic [3:0]        out_d1;
	logic [3:0]        out_q;
	logic              en_pre;
	logic              en_d1;
	logic              en_q;
	logic [3:0]        in_mt0;
	logic [3:0]        in_mt1;
	logic [3:0]        in_sync;
	logic [3:0]        rd_tag;
	logic [data_w-1:0] rd_sr;

	// position inside the phase; a nibble phase runs address 0..5, then data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx <= '0;
		else if (fall_edge)
			idx <= phase_start ? '0 : idx + 1'b1;
	end

	assign cmd_byte = cur_we ? write_cmd : read_cmd;
	assign adr_pos = 3'd5 - idx[2:0];
	assign adr_nib = dev_adr[{adr_pos, 2'b00} +: 4];
	// data nibble number is idx - 6, bytes in address order, high nibble first
	assign wr_pos = idx[2:0] - 3'd6;
	assign wr_nib = cur_wdata[{wr_pos[2:1], ~wr_pos[0], 2'b00} +: 4];

	always_comb begin
		case (phase)
			ph_cmd: begin
				out_pre = {3'b000, cmd_byte[~idx[2:0]]};
				en_pre = 1'b1;
			end
			ph_nibble: begin
				out_pre = (idx < 4'd6) ? adr_nib : wr_nib;
				en_pre = 1'b1;
			end
			default: begin
				out_pre = 4'h0;
				en_pre = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_d1 <= 4'h0;
			out_q <= 4'h0;
			en_d1 <= 1'b0;
			en_q <= 1'b0;
		end else begin
			out_d1 <= out_pre;
			out_q <= out_d1;
			en_d1 <= en_pre;
			en_q <= en_d1;
		end
	end

	assign sio = en_q ? out_q : 4'hz;

	// rd_tag delays the read phase to meet the matching rise strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_mt0 <= 4'h0;
			in_mt1 <= 4'h0;
			in_sync <= 4'h0;
			rd_tag <= 4'h0;
			nibble_done <= 1'b0;
		end else begin
			in_mt0 <= sio;
			in_mt1 <= in_mt0;
			in_sync <= in_mt1;
			rd_tag <= {rd_tag[2:0], phase == ph_read};
			nibble_done <= rise_edge & rd_tag[3];
		end
	end

	always_ff @(posedge clk) begin
		if (rise_edge && rd_tag[3])
			rd_sr <= {rd_sr[data_w-5:0], in_sync};
	end

	// first byte arrived lands lowest
	always_comb begin
		case (cur_size)
			size_word: rdata = {rd_sr[7:0], rd_sr[15:8], rd_sr[23:16], rd_sr[31:24]};
			size_half: rdata = {16'd0, rd_sr[7:0], rd_sr[15:8]};
			default: rdata = {24'd0, rd_sr[7:0]};
		endcase
	end

endmodule

`default_nettype wire

/* logic/qspi_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// quad-SPI memory controller top, host req/ack port and
// config register bus in front of up to three devices
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module qspi_if
	import qspi_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  size_t                 size,
	input  logic [host_adr_w-1:0] adr,
	input  logic [data_w-1:0]     wdata,
	output logic                  ack,
	output logic [data_w-1:0]     rdata,
	input  logic                  cfg_we,
	input  logic                  cfg_re,
	input  logic [cfg_adr_w-1:0]  cfg_adr,
	input  logic [data_w-1:0]     cfg_wdata,
	output logic [data_w-1:0]     cfg_rdata,
	output logic                  sck,
	output logic [2:0]            ce_n,
	inout  wire  [3:0]            sio
);

	logic                  fall_edge;
	logic                  rise_edge;
	logic [div_w-1:0]      sck_div;
	logic [2:0][lat_w-1:0] read_latency;
	phase_t                phase;
	logic                  phase_start;
	logic [dev_adr_w-1:0]  dev_adr;
	size_t                 cur_size;
	logic [data_w-1:0]     cur_wdata;
	logic                  cur_we;
	logic                  nibble_done;

	qspi_clock_gen i_clock_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.sck_div   (sck_div),
		.sck       (sck),
		.fall_edge (fall_edge),
		.rise_edge (rise_edge)
	);

	qspi_config_regs i_config_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg_we       (cfg_we),
		.cfg_re       (cfg_re),
		.cfg_adr      (cfg_adr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.sck_div      (sck_div),
		.read_latency (read_latency)
	);

	qspi_sequencer i_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (req),
		.we           (we),
		.fall_edge    (fall_edge),
		.size         (size),
		.adr          (adr),
		.wdata        (wdata),
		.read_latency (read_latency),
		.ack          (ack),
		.ce_n         (ce_n),
		.phase        (phase),
		.dev_adr      (dev_adr),
		.cur_size     (cur_size),
		.cur_wdata    (cur_wdata),
		.cur_we       (cur_we),
		.phase_start  (phase_start),
		.nibble_done  (nibble_done)
	);

	qspi_shifter i_shifter (
		.clk         (clk),
		.rst_n       (rst_n),
		.fall_edge   (fall_edge),
		.rise_edge   (rise_edge),
		.phase_start (phase_start),
		.cur_we      (cur_we),
		.phase       (phase),
		.dev_adr     (dev_adr),
		.cur_size    (cur_size),
		.cur_wdata   (cur_wdata),
		.sio         (sio),
		.nibble_done (nibble_done),
		.rdata       (rdata)
	);

endmodule

`default_nettype wire

/* bench/qspi_mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral quad-SPI memory device for the testbench, one per
// chip select, with a fixed dummy-clock count and sparse storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module qspi_mem_model
	import qspi_pkg::*;
#(
	parameter int dummy_clocks = 6
) (
	input  wire       ce_n,
	input  wire       sck,
	inout  wire [3:0] sio
);

	logic [7:0]  mem [logic [23:0]];
	int unsigned rises = 0;
	int unsigned nib = 0;
	logic [7:0]  cmd = 8'h00;
	logic [23:0] adr = 24'h0;
	logic [3:0]  hi_nib = 4'h0;
	logic [3:0]  drv_nib = 4'h0;
	logic        drv_en = 1'b0;
	logic [7:0]  rd_byte = 8'h00;

	// untouched locations read back a pattern of the whole address
	function automatic logic [7:0] peek(input logic [23:0] a);
		if (mem.exists(a))
			return mem[a];
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
	endfunction

	always @(posedge ce_n or posedge sck or negedge sck) begin
		if (ce_n) begin
			rises = 0;
			drv_en = 1'b0;
		end else if (sck) begin
			// 8 command bits, then 6 address nibbles, then data
			if (rises < 8) begin
				cmd = {cmd[6:0], sio[0]};
			end else if (rises < 14) begin
				adr = {adr[19:0], sio};
			end else if (cmd == write_cmd) begin
				// high nibble first
				if (rises[0] == 1'b0) begin
					hi_nib = sio;
				end else begin
					mem[adr] = {hi_nib, sio};
					adr = adr + 24'd1;
				end
			end
			rises = rises + 1;
		end else if (cmd == read_cmd && rises >= 14 + dummy_clocks) begin
			// read data changes on the falling edge after the dummy clocks
			nib = rises - 14 - dummy_clocks;
			rd_byte = peek(adr + 24'(nib >> 1));
			drv_nib = nib[0] ? rd_byte[3:0] : rd_byte[7:4];
			drv_en = 1'b1;
		end
	end

	assign sio = (drv_en && !ce_n) ? drv_nib : 4'hz;

endmodule

`default_nettype wire

/* bench/qspi_if_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the quad-SPI controller with three
// memory models on the chip selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module qspi_if_tb
	import qspi_pkg::*;
();

	localparam int clk_period = 8;
	// longest transfer in SCK periods with slack, at the default divider
	localparam int xfer_periods = 48;
	localparam int xfer_clocks = xfer_periods * 2 * (int'(sckdiv_default) + 1);
	localparam int watchdog_ns = 200 * xfer_clocks * clk_period;

	logic                  clk;
	logic                  rst_n;
	logic                  req;
	logic                  we;
	size_t                 size;
	logic [host_adr_w-1:0] adr;
	logic [data_w-1:0]     wdata;
	logic                  ack;
	logic [data_w-1:0]     rdata;
	logic                  cfg_we;
	logic                  cfg_re;
	logic [cfg_adr_w-1:0]  cfg_adr;
	logic [data_w-1:0]     cfg_wdata;
	logic [data_w-1:0]     cfg_rdata;
	logic                  sck;
	logic [2:0]            ce_n;
	wire  [3:0]            sio;

	string cur_test;
	int    tests_run;
	int    checks_run;
	int    errors;
	int    errors_at_start;

	qspi_if i_qspi_if (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.we        (we),
		.size      (size),
		.adr       (adr),
		.wdata     (wdata),
		.ack       (ack),
		.rdata     (rdata),
		.cfg_we    (cfg_we),
		.cfg_re    (cfg_re),
		.cfg_adr   (cfg_adr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.sck       (sck),
		.ce_n      (ce_n),
		.sio       (sio)
	);

	qspi_mem_model #(.dummy_clocks(6)) i_mem0 (.ce_n(ce_n[0]), .sck(sck), .sio(sio));
	qspi_mem_model #(.dummy_clocks(6)) i_mem1 (.ce_n(ce_n[1]), .sck(sck), .sio(sio));
	qspi_mem_model #(.dummy_clocks(8)) i_mem2 (.ce_n(ce_n[2]), .sck(sck), .sio(sio));

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic check(input logic [31:0] expected, input logic [31:0] actual);
		checks_run++;
		if (expected !== actual) begin
			errors++;
			$display("Error: %s expected %h actual %h", cur_test, expected, actual);
		end
	endtask

	task automatic report(input string what);
		errors++;
		$display("%s: %s", cur_test, what);
	endtask

	// inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		tests_run++;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		$display("%-16s %s", cur_test, (errors == errors_at_start) ? "passed" : "failed");
	endtask

	// memory model fill for a word never written
	function automatic logic [data_w-1:0] fill_word(input logic [dev_adr_w-1:0] a);
		logic [data_w-1:0] w;
		logic [23:0]       b;
		for (int i = 0; i < 4; i++) begin
			b = a + 24'(i);
			w[8*i +: 8] = b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'h5a;
		end
		return w;
	endfunction

	// clocks between two sck changes, after lining up on one
	task automatic sck_half_period(output int clocks);
		logic last;
		int   n;
		last = sck;
		n = 0;
		while (sck == last && n < 64) begin
			tick();
			n++;
		end
		last = sck;
		clocks = 0;
		while (sck == last && clocks < 64) begin
			tick();
			clocks++;
		end
	endtask

	task automatic request(input logic wr, input size_t sz,
			input logic [host_adr_w-1:0] a, input logic [data_w-1:0] d);
		int n;
		req = 1'b1;
		we = wr;
		size = sz;
		adr = a;
		wdata = d;
		n = 0;
		while (!ack && n < xfer_clocks) begin
			tick();
			n++;
		end
		if (!ack)
			report("no ack from the controller within the transfer time");
	endtask

	// ack must drop on the cycle after req falls
	task automatic release_req();
		req = 1'b0;
		tick();
		check(32'd0, 32'(ack));
	endtask

	task automatic host_write(input logic [host_adr_w-1:0] a, input size_t sz,
			input logic [data_w-1:0] d);
		request(1'b1, sz, a, d);
		release_req();
	endtask

	task automatic host_read(input logic [host_adr_w-1:0] a, input size_t sz,
			output logic [data_w-1:0] q);
		request(1'b0, sz, a, '0);
		q = rdata;
		release_req();
	endtask

	task automatic cfg_write(input logic [cfg_adr_w-1:0] a, input logic [data_w-1:0] d);
		cfg_we = 1'b1;
		cfg_adr = a;
		cfg_wdata = d;
		tick();
		cfg_we = 1'b0;
	endtask

	task automatic cfg_read(input logic [cfg_adr_w-1:0] a, output logic [data_w-1:0] q);
		cfg_re = 1'b1;
		cfg_adr = a;
		tick();
		cfg_re = 1'b0;
		q = cfg_rdata;
	endtask

	task automatic defaults_after_reset();
		logic [data_w-1:0] q;
		int                half;
		begin_test("reset_defaults");
		check(32'd0, 32'(ack));
		check(32'h7, 32'(ce_n));
		check(32'd0, cfg_rdata);
		cfg_read(reg_latency0, q);
		check(32'(latency_default), q);
		cfg_read(reg_latency1, q);
		check(32'(latency_default), q);
		cfg_read(reg_latency2, q);
		check(32'(latency_default), q);
		cfg_read(reg_sckdiv, q);
		check(32'(sckdiv_default), q);
		// unmapped register
		cfg_read(4'hf, q);
		check(32'd0, q);
		// half period is the divider plus one
		sck_half_period(half);
		check(32'(sckdiv_default) + 32'd1, 32'(half));
		end_test();
	endtask

	task automatic word_write_read();
		logic [31:0]           r;
		logic [host_adr_w-1:0] a;
		logic [data_w-1:0]     d;
		logic [data_w-1:0]     q;
		begin_test("word_rw");
		r = $urandom;
		a = {2'b00, r[23:2], 2'b00};
		d = $urandom;
		host_write(a, size_word, d);
		host_read(a, size_word, q);
		check(d, q);
		end_test();
	endtask

	task automatic byte_half_merge();
		logic [31:0]           r;
		logic [host_adr_w-1:0] a;
		logic [data_w-1:0]     w;
		logic [data_w-1:0]     b;
		logic [data_w-1:0]     h;
		logic [data_w-1:0]     q;
		begin_test("byte_half");
		r = $urandom;
		a = {2'b00, r[23:2], 2'b00};
		w = $urandom;
		b = $urandom;
		h = $urandom;
		host_write(a, size_word, w);
		// upper wdata bits are junk and must not reach the device
		host_write(a + 26'd1, size_byte, b);
		host_write(a + 26'd2, size_half, h);
		host_read(a, size_word, q);
		check({h[15:0], b[7:0], w[7:0]}, q);
		host_read(a + 26'd1, size_byte, q);
		check({24'd0, b[7:0]}, q);
		host_read(a + 26'd2, size_half, q);
		check({16'd0, h[15:0]}, q);
		host_read(a + 26'd3, size_byte, q);
		check({24'd0, h[15:8]}, q);
		end_test();
	endtask

	task automatic device2_fast_clock();
		logic [31:0]          r;
		logic [dev_adr_w-1:0] off;
		logic [data_w-1:0]    d;
		logic [data_w-1:0]    q;
		int                   half;
		begin_test("device2_fast");
		cfg_write(reg_latency2, 32'd8);
		cfg_write(reg_sckdiv, 32'd1);
		cfg_read(reg_latency2, q);
		check(32'd8, q);
		cfg_read(reg_sckdiv, q);
		check(32'd1, q);
		sck_half_period(half);
		check(32'd2, 32'(half));
		r = $urandom;
		off = {r[23:2], 2'b00};
		d = $urandom;
		host_write({2'b10, off}, size_word, d);
		host_read({2'b10, off}, size_word, q);
		check(d, q);
		// same offset on the other devices still holds the model fill
		host_read({2'b00, off}, size_word, q);
		check(fill_word(off), q);
		host_read({2'b01, off}, size_word, q);
		check(fill_word(off), q);
		end_test();
	endtask

	task automatic handshake_hold();
		logic [31:0]           r;
		logic [host_adr_w-1:0] a;
		logic [data_w-1:0]     d;
		logic [data_w-1:0]     q;
		int                    busy;
		int                    held;
		begin_test("handshake");
		r = $urandom;
		a = {2'b01, r[23:2], 2'b00};
		d = $urandom;
		request(1'b1, size_word, a, d);
		busy = 0;
		held = 0;
		// req stays high, so the bus must stay quiet
		repeat (40) begin
			tick();
			if (ce_n != 3'b111)
				busy++;
			if (ack)
				held++;
		end
		check(32'd0, 32'(busy));
		check(32'd40, 32'(held));
		release_req();
		host_read(a, size_word, q);
		check(d, q);
		end_test();
	endtask

	initial begin
		void'($urandom(50791));
		cur_test = "";
		tests_run = 0;
		checks_run = 0;
		errors = 0;
		errors_at_start = 0;
		rst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		size = size_byte;
		adr = '0;
		wdata = '0;
		cfg_we = 1'b0;
		cfg_re = 1'b0;
		cfg_adr = '0;
		cfg_wdata = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		defaults_after_reset();
		word_write_read();
		byte_half_merge();
		device2_fast_clock();
		handshake_hold();

		$display("tests %0d  checks %0d  errors %0d", tests_run, checks_run, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
logic/qspi_pkg.sv
logic/qspi_clock_gen.sv
logic/qspi_config_regs.sv
logic/qspi_sequencer.sv
logic/qspi_shifter.sv
logic/qspi_if.sv
bench/qspi_mem_model.sv
bench/qspi_if_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module qspi_if_tb -f sources.f -o qspi_sim
	./obj_dir/qspi_sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
